//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := decode_exec_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status comes from the search for the pass line
run: compile
	$(SIM_BIN) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+common
common/rv_core_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/pipe_reg.sv
execute/alu.sv
execute/branch_cmp.sv
execute/exec_result.sv
hdl/decode_exec_top.sv
verification/decode_exec_sva.sv
verification/decode_exec_tb.sv

//--- common/rv_core_params.svh
// core sizing macros shared by the decode and execute blocks
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data path and address width
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// index width into the register file
`define REG_ADDR_W 5

`endif

//--- common/rv_core_pkg.sv
// shared opcode, control encodings and ID/EX payload types for the RV32I slice
`default_nettype none

`include "rv_core_params.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    // funct3 codes of the conditional branches
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_e;

    typedef struct packed {
        logic         reg_write;
        result_src_e  result_src;
        logic         mem_write;
        logic         jump;
        logic         jalr;
        logic         branch;
        alu_op_e      alu_op;
        logic         alu_src;   // 1 selects the immediate
        branch_cond_e branch_cond;
    } ctrl_bundle_t;

    typedef struct packed {
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc_plus4;
    } data_bundle_t;

endpackage

`default_nettype wire

//--- execute/alu.sv
// execute stage arithmetic and logic unit with register or immediate operand B
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module alu (
    input  rv_core_pkg::alu_op_e op_i,
    input  logic                 alu_src_i,
    input  logic [`XLEN-1:0]     rs1_i,
    input  logic [`XLEN-1:0]     rs2_i,
    input  logic [`XLEN-1:0]     imm_i,
    output logic [`XLEN-1:0]     result_o
);
    import rv_core_pkg::*;

    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;

    assign op_b  = alu_src_i ? imm_i : rs2_i;
    assign shamt = op_b[4:0];  // only low bits matter for shifts

    always_comb
    begin
        case (op_i)
            ALU_ADD:    result_o = rs1_i + op_b;
            ALU_SUB:    result_o = rs1_i - op_b;
            ALU_SLL:    result_o = rs1_i << shamt;
            ALU_SLT:    result_o = {{(`XLEN-1){1'b0}}, $signed(rs1_i) < $signed(op_b)};
            ALU_SLTU:   result_o = {{(`XLEN-1){1'b0}}, rs1_i < op_b};
            ALU_XOR:    result_o = rs1_i ^ op_b;
            ALU_SRL:    result_o = rs1_i >> shamt;
            ALU_SRA:    result_o = $signed(rs1_i) >>> shamt;
            ALU_OR:     result_o = rs1_i | op_b;
            ALU_AND:    result_o = rs1_i & op_b;
            ALU_PASS_B: result_o = op_b;
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- execute/branch_cmp.sv
// branch comparator, evaluates the funct3 condition on both register operands
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module branch_cmp (
    input  rv_core_pkg::branch_cond_e cond_i,
    input  logic [`XLEN-1:0]          rs1_i,
    input  logic [`XLEN-1:0]          rs2_i,
    output logic                      taken_o
);
    import rv_core_pkg::*;

    always_comb
    begin
        case (cond_i)
            BR_EQ:   taken_o = (rs1_i == rs2_i);
            BR_NE:   taken_o = (rs1_i != rs2_i);
            BR_LT:   taken_o = ($signed(rs1_i) <  $signed(rs2_i));
            BR_GE:   taken_o = ($signed(rs1_i) >= $signed(rs2_i));
            BR_LTU:  taken_o = (rs1_i <  rs2_i);
            BR_GEU:  taken_o = (rs1_i >= rs2_i);
            default: taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- execute/exec_result.sv
// execute result stage, picks writeback value, target pc and the redirect
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module exec_result (
    input  rv_core_pkg::ctrl_bundle_t ctrl_i,
    input  rv_core_pkg::data_bundle_t data_i,
    input  logic [`XLEN-1:0]          alu_result_i,
    input  logic                      taken_i,
    output logic [`XLEN-1:0]          wb_value_o,
    output logic [`XLEN-1:0]          target_pc_o,
    output logic                      redirect_o
);
    import rv_core_pkg::*;

    // jumps always leave, branches only when the comparator agrees
    assign redirect_o = ctrl_i.jump | (ctrl_i.branch & taken_i);

    // jalr target is rs1 + imm from the alu, lsb cleared
    assign target_pc_o = ctrl_i.jalr ? {alu_result_i[`XLEN-1:1], 1'b0}
                                     : data_i.pc + data_i.imm;

    // link address for jal and jalr
    assign wb_value_o = (ctrl_i.result_src == RES_PC4) ? data_i.pc_plus4 : alu_result_i;

endmodule

`default_nettype wire

//--- hdl/decode_exec_top.sv
// decode to execute slice of the RV32I pipeline, decode, register file, ID/EX and execute
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module decode_exec_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic [`XLEN-1:0]         instr_i,
    input  logic [`XLEN-1:0]         pc_i,
    input  logic                     instr_valid_i,
    input  logic                     wb_we_i,
    input  logic [`REG_ADDR_W-1:0]   wb_rd_i,
    input  logic [`XLEN-1:0]         wb_data_i,
    output logic                     ex_reg_write_o,
    output logic                     ex_mem_write_o,
    output rv_core_pkg::result_src_e ex_result_src_o,
    output logic [`REG_ADDR_W-1:0]   ex_rd_o,
    output logic [`XLEN-1:0]         ex_wb_value_o,
    output logic [`XLEN-1:0]         ex_store_data_o,
    output logic [`XLEN-1:0]         ex_pc_plus4_o,
    output logic                     redirect_o,
    output logic [`XLEN-1:0]         target_pc_o
);
    import rv_core_pkg::*;

    ctrl_bundle_t           ctrl_d;
    ctrl_bundle_t           ctrl_q;
    data_bundle_t           data_d;
    data_bundle_t           data_q;
    logic [`XLEN-1:0]       imm_d;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic [`XLEN-1:0]       alu_result;
    logic                   br_taken;

    instr_decoder decoder_i (
        .instr_i (instr_i),
        .valid_i (instr_valid_i),
        .ctrl_o  (ctrl_d),
        .imm_o   (imm_d),
        .rs1_o   (rs1_addr),
        .rs2_o   (rs2_addr),
        .rd_o    (rd_addr)
    );

    reg_file reg_file_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .we_i     (wb_we_i),
        .waddr_i  (wb_rd_i),
        .wdata_i  (wb_data_i),
        .rdata1_o (rs1_val),
        .rdata2_o (rs2_val)
    );

    // decode side of the ID/EX data payload
    assign data_d.rs1_val  = rs1_val;
    assign data_d.rs2_val  = rs2_val;
    assign data_d.pc       = pc_i;
    assign data_d.rd       = rd_addr;
    assign data_d.imm      = imm_d;
    assign data_d.pc_plus4 = pc_i + `XLEN'(4);

    // taken branch or jump squashes the wrong-path instruction
    pipe_reg #(.payload_t(ctrl_bundle_t)) ctrl_pipe_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (redirect_o),
        .d_i      (ctrl_d),
        .q_o      (ctrl_q)
    );

    pipe_reg #(.payload_t(data_bundle_t)) data_pipe_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (redirect_o),
        .d_i      (data_d),
        .q_o      (data_q)
    );

    alu alu_i (
        .op_i      (ctrl_q.alu_op),
        .alu_src_i (ctrl_q.alu_src),
        .rs1_i     (data_q.rs1_val),
        .rs2_i     (data_q.rs2_val),
        .imm_i     (data_q.imm),
        .result_o  (alu_result)
    );

    branch_cmp branch_cmp_i (
        .cond_i  (ctrl_q.branch_cond),
        .rs1_i   (data_q.rs1_val),
        .rs2_i   (data_q.rs2_val),
        .taken_o (br_taken)
    );

    exec_result exec_result_i (
        .ctrl_i       (ctrl_q),
        .data_i       (data_q),
        .alu_result_i (alu_result),
        .taken_i      (br_taken),
        .wb_value_o   (ex_wb_value_o),
        .target_pc_o  (target_pc_o),
        .redirect_o   (redirect_o)
    );

    assign ex_reg_write_o  = ctrl_q.reg_write;
    assign ex_mem_write_o  = ctrl_q.mem_write;
    assign ex_result_src_o = ctrl_q.result_src;
    assign ex_rd_o         = data_q.rd;
    assign ex_store_data_o = data_q.rs2_val;  // sw data
    assign ex_pc_plus4_o   = data_q.pc_plus4;

endmodule

`default_nettype wire

//--- hdl/instr_decoder.sv
// instruction decoder producing control fields, register indices and the extended immediate
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module instr_decoder (
    input  logic [`XLEN-1:0]           instr_i,
    input  logic                       valid_i,
    output rv_core_pkg::ctrl_bundle_t  ctrl_o,
    output logic [`XLEN-1:0]           imm_o,
    output logic [`REG_ADDR_W-1:0]     rs1_o,
    output logic [`REG_ADDR_W-1:0]     rs2_o,
    output logic [`REG_ADDR_W-1:0]     rd_o
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_b5;     // selects sub and sra
    alu_op_e    arith_op;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign f7_b5  = instr_i[30];

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    // shared by R-type and I-type, sub only exists for R-type
    always_comb
    begin
        case (funct3)
            3'b000:  arith_op = (opcode == OP_REG && f7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = f7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb
    begin
        ctrl_o = '0;  // bubble unless a supported opcode is seen
        if (valid_i)
        begin
            case (opcode)
                OP_REG:
                begin
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.alu_op    = arith_op;
                end
                OP_IMM:
                begin
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.alu_op    = arith_op;
                    ctrl_o.alu_src   = 1'b1;
                end
                OP_LUI:
                begin
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.alu_op    = ALU_PASS_B;
                    ctrl_o.alu_src   = 1'b1;
                end
                OP_LOAD:
                begin
                    ctrl_o.reg_write  = 1'b1;
                    ctrl_o.result_src = RES_MEM;
                    ctrl_o.alu_src    = 1'b1;  // address = rs1 + imm
                end
                OP_STORE:
                begin
                    ctrl_o.mem_write = 1'b1;
                    ctrl_o.alu_src   = 1'b1;
                end
                OP_BRANCH:
                begin
                    // funct3 010 and 011 are not branches
                    if (funct3[2:1] != 2'b01)
                    begin
                        ctrl_o.branch      = 1'b1;
                        ctrl_o.branch_cond = branch_cond_e'(funct3);
                    end
                end
                OP_JAL:
                begin
                    ctrl_o.reg_write  = 1'b1;
                    ctrl_o.result_src = RES_PC4;
                    ctrl_o.jump       = 1'b1;
                end
                OP_JALR:
                begin
                    ctrl_o.reg_write  = 1'b1;
                    ctrl_o.result_src = RES_PC4;
                    ctrl_o.jump       = 1'b1;
                    ctrl_o.jalr       = 1'b1;
                    ctrl_o.alu_src    = 1'b1;  // target comes from the alu sum
                end
                default: ctrl_o = '0;
            endcase
        end
    end

    // immediate formats by opcode
    always_comb
    begin
        case (opcode)
            OP_IMM, OP_LOAD, OP_JALR:
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            OP_STORE:
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            OP_BRANCH:
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            OP_LUI:
                imm_o = {instr_i[31:12], 12'b0};
            OP_JAL:
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/pipe_reg.sv
// ID/EX pipeline register for any packed payload, with flush to a bubble
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
)(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     flush_i,   // squash the stage being entered
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            q_o <= '0;
        end
        else if (flush_i)
        begin
            q_o <= '0;  // all zero is a bubble
        end
        else
        begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// integer register file, two combinational read ports and one write port
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module reg_file (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o
);

    logic [`XLEN-1:0] regs [0:`REG_COUNT-1];

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (we_i && waddr_i != '0)  // x0 never written
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is forwarded to the readers
    assign rdata1_o = (raddr1_i == '0)                  ? '0      :
                      (we_i && waddr_i == raddr1_i)     ? wdata_i :
                                                          regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                  ? '0      :
                      (we_i && waddr_i == raddr2_i)     ? wdata_i :
                                                          regs[raddr2_i];

endmodule

`default_nettype wire

//--- verification/decode_exec_sva.sv
// concurrent assertions on the decode to execute slice, bound to its top level
`timescale 1ns/1ps
`default_nettype none

module decode_exec_sva (
    input logic clk_i,
    input logic arst_n_i,
    input logic reg_write_i,
    input logic mem_write_i,
    input logic redirect_i
);

    // a redirect flushes its follower, so two in a row cannot happen
    property single_redirect;
        @(posedge clk_i) disable iff (!arst_n_i)
            redirect_i |=> !redirect_i;
    endproperty

    // from the second edge of reset on
    property quiet_in_reset;
        @(posedge clk_i)
            (!arst_n_i && !$past(arst_n_i)) |-> (!reg_write_i && !mem_write_i && !redirect_i);
    endproperty

    property one_write_kind;
        @(posedge clk_i) disable iff (!arst_n_i)
            !(reg_write_i && mem_write_i);
    endproperty

    a_single_redirect: assert property (single_redirect)
        else $error("redirect_o high on two consecutive cycles");
    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("control output active during reset");
    a_one_write_kind: assert property (one_write_kind)
        else $error("register write and memory write active together");

endmodule

bind decode_exec_top decode_exec_sva decode_exec_sva_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .reg_write_i (ex_reg_write_o),
    .mem_write_i (ex_mem_write_o),
    .redirect_i  (redirect_o)
);

`default_nettype wire

//--- verification/decode_exec_tb.sv
// testbench for the decode to execute slice, random RV32I stream checked against an ISA model
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module decode_exec_tb;
    import rv_core_pkg::*;

    localparam int N_INSTR   = 2000;
    localparam int MAX_CYCLE = N_INSTR + 8 + 32;

    logic                   clk_i;
    logic                   arst_n_i;
    logic [`XLEN-1:0]       instr_i;
    logic [`XLEN-1:0]       pc_i;
    logic                   instr_valid_i;
    logic                   wb_we_i;
    logic [`REG_ADDR_W-1:0] wb_rd_i;
    logic [`XLEN-1:0]       wb_data_i;
    logic                   ex_reg_write_o;
    logic                   ex_mem_write_o;
    result_src_e            ex_result_src_o;
    logic [`REG_ADDR_W-1:0] ex_rd_o;
    logic [`XLEN-1:0]       ex_wb_value_o;
    logic [`XLEN-1:0]       ex_store_data_o;
    logic [`XLEN-1:0]       ex_pc_plus4_o;
    logic                   redirect_o;
    logic [`XLEN-1:0]       target_pc_o;

    logic [`XLEN-1:0]       model_regs [0:`REG_COUNT-1];
    integer                 seed;
    int                     n_checks;
    int                     n_errors;
    int                     cycle_cnt;
    logic                   flush_next;

    // prediction for the instruction now in execute
    logic                   exp_rw;
    logic                   exp_mw;
    logic                   exp_redir;
    result_src_e            exp_src;
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic [`XLEN-1:0]       exp_wb;
    logic [`XLEN-1:0]       exp_target;
    logic [`XLEN-1:0]       exp_store;
    logic [`XLEN-1:0]       exp_pc4;
    logic                   chk_wb;
    logic                   chk_target;
    logic                   chk_store;
    logic                   chk_pc4;

    decode_exec_top decode_exec_top_i (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] idx);
        if (idx == '0)
            return '0;
        if (wb_we_i && wb_rd_i == idx)
            return wb_data_i;  // write on the same edge is seen
        return model_regs[idx];
    endfunction

    function automatic logic [`XLEN-1:0] arith(input logic [2:0] f3, input logic alt,
                                               input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic taken(input logic [2:0] f3, input logic [`XLEN-1:0] a,
                                   input logic [`XLEN-1:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic is_supported(input logic [6:0] op);
        return op inside {OP_LOAD, OP_IMM, OP_STORE, OP_REG, OP_LUI, OP_BRANCH, OP_JALR, OP_JAL};
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] pick_reg();
        if ({$random(seed)} % 5 == 0)
            return '0;  // x0 about one time in five
        return 5'($random(seed));
    endfunction

    function automatic logic [`XLEN-1:0] random_instr();
        logic [`XLEN-1:0] r;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic [6:0]       op;
        int               kind;
        r    = $random(seed);
        f3   = r[14:12];
        kind = {$random(seed)} % 16;
        case (kind)
            0, 1, 2, 3:
            begin
                f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                return {f7, pick_reg(), pick_reg(), f3, pick_reg(), OP_REG};
            end
            4, 5, 6:
            begin
                f7 = r[31:25];
                if (f3 == 3'd1)
                    f7 = 7'h00;
                else if (f3 == 3'd5)
                    f7 = r[30] ? 7'h20 : 7'h00;  // srai or srli
                return {f7, r[24:20], pick_reg(), f3, pick_reg(), OP_IMM};
            end
            7:  return {r[31:12], pick_reg(), OP_LUI};
            8:  return {r[31:20], pick_reg(), 3'b010, pick_reg(), OP_LOAD};
            9:  return {r[31:25], pick_reg(), pick_reg(), 3'b010, r[11:7], OP_STORE};
            10, 11, 12:
            begin
                f3 = 3'({$random(seed)} % 6);
                if (f3 >= 3'd2)
                    f3 = f3 + 3'd2;  // skip the two unused codes
                return {r[31:25], pick_reg(), pick_reg(), f3, r[11:7], OP_BRANCH};
            end
            13: return {r[31:12], pick_reg(), OP_JAL};
            14: return {r[31:20], pick_reg(), 3'b000, pick_reg(), OP_JALR};
            default:
            begin
                op = {r[6:2], 2'b11};
                if (is_supported(op))
                    op = 7'b1110011;  // system opcode, not handled here
                return {r[31:7], op};
            end
        endcase
    endfunction

    task automatic drive_random();
        instr_i       = random_instr();
        pc_i          = {$random(seed)} & 32'hffff_fffc;
        instr_valid_i = ({$random(seed)} % 10) != 0;
        wb_we_i       = ({$random(seed)} % 8) != 0;
        wb_rd_i       = pick_reg();
        wb_data_i     = $random(seed);
        if ({$random(seed)} % 4 == 0)
            wb_data_i = wb_data_i % 4;  // small values so equal compares happen
    endtask

    task automatic drive_idle();
        instr_valid_i = 1'b0;
        wb_we_i       = 1'b0;
    endtask

    task automatic predict(input logic flushed);
        logic [6:0]       op;
        logic [2:0]       f3;
        logic [`XLEN-1:0] rs1v;
        logic [`XLEN-1:0] rs2v;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] imm_b;
        logic [`XLEN-1:0] imm_j;
        op    = instr_i[6:0];
        f3    = instr_i[14:12];
        rs1v  = read_reg(instr_i[19:15]);
        rs2v  = read_reg(instr_i[24:20]);
        imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
        imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
        imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
        exp_rw     = 1'b0;
        exp_mw     = 1'b0;
        exp_redir  = 1'b0;
        exp_src    = RES_ALU;
        exp_rd     = instr_i[11:7];
        exp_pc4    = pc_i + 32'd4;
        exp_store  = rs2v;
        chk_wb     = 1'b0;
        chk_target = 1'b0;
        chk_store  = 1'b0;
        chk_pc4    = !flushed;  // pc+4 is captured even for a bubble
        if (!flushed && instr_valid_i)
        begin
            case (op)
                OP_REG:
                begin
                    exp_rw = 1'b1;
                    exp_wb = arith(f3, instr_i[30], rs1v, rs2v);
                    chk_wb = 1'b1;
                end
                OP_IMM:
                begin
                    exp_rw = 1'b1;
                    exp_wb = arith(f3, f3 == 3'd5 && instr_i[30], rs1v, imm_i);
                    chk_wb = 1'b1;
                end
                OP_LUI:
                begin
                    exp_rw = 1'b1;
                    exp_wb = {instr_i[31:12], 12'b0};
                    chk_wb = 1'b1;
                end
                OP_LOAD:
                begin
                    exp_rw  = 1'b1;
                    exp_src = RES_MEM;
                    exp_wb  = rs1v + imm_i;  // effective address
                    chk_wb  = 1'b1;
                end
                OP_STORE:
                begin
                    exp_mw    = 1'b1;
                    exp_wb    = rs1v + imm_s;
                    chk_wb    = 1'b1;
                    chk_store = 1'b1;
                end
                OP_BRANCH:
                begin
                    if (f3[2:1] != 2'b01)
                    begin
                        exp_redir  = taken(f3, rs1v, rs2v);
                        exp_target = pc_i + imm_b;
                        chk_target = 1'b1;
                    end
                end
                OP_JAL, OP_JALR:
                begin
                    exp_rw     = 1'b1;
                    exp_src    = RES_PC4;
                    exp_redir  = 1'b1;
                    exp_wb     = pc_i + 32'd4;  // link address
                    exp_target = (op == OP_JAL) ? pc_i + imm_j : (rs1v + imm_i) & ~32'd1;
                    chk_wb     = 1'b1;
                    chk_target = 1'b1;
                end
                default:
                begin
                    exp_rw = 1'b0;  // unsupported opcode is a bubble
                end
            endcase
        end
    endtask

    task automatic report_mismatch(input string what, input logic [`XLEN-1:0] got,
                                   input logic [`XLEN-1:0] want);
        n_errors++;
        $display("ERROR at time %0t: %s is %h, model expects %h", $time, what, got, want);
    endtask

    task automatic check_outputs();
        n_checks++;
        if (ex_reg_write_o !== exp_rw)
            report_mismatch("ex_reg_write_o", 32'(ex_reg_write_o), 32'(exp_rw));
        if (ex_mem_write_o !== exp_mw)
            report_mismatch("ex_mem_write_o", 32'(ex_mem_write_o), 32'(exp_mw));
        if (ex_result_src_o !== exp_src)
            report_mismatch("ex_result_src_o", 32'(ex_result_src_o), 32'(exp_src));
        if (redirect_o !== exp_redir)
            report_mismatch("redirect_o", 32'(redirect_o), 32'(exp_redir));
        if (chk_wb && ex_wb_value_o !== exp_wb)
            report_mismatch("ex_wb_value_o", ex_wb_value_o, exp_wb);
        if (chk_target && target_pc_o !== exp_target)
            report_mismatch("target_pc_o", target_pc_o, exp_target);
        if (exp_rw && ex_rd_o !== exp_rd)
            report_mismatch("ex_rd_o", 32'(ex_rd_o), 32'(exp_rd));
        if (chk_store && ex_store_data_o !== exp_store)
            report_mismatch("ex_store_data_o", ex_store_data_o, exp_store);
        if (chk_pc4 && ex_pc_plus4_o !== exp_pc4)
            report_mismatch("ex_pc_plus4_o", ex_pc_plus4_o, exp_pc4);
    endtask

    task automatic check_reset_state();
        n_checks++;
        if ({ex_reg_write_o, ex_mem_write_o, redirect_o} !== 3'b000)
            report_mismatch("controls in reset",
                            32'({ex_reg_write_o, ex_mem_write_o, redirect_o}), '0);
        if (ex_result_src_o !== RES_ALU)
            report_mismatch("ex_result_src_o in reset", 32'(ex_result_src_o), '0);
        if (ex_wb_value_o !== '0 || ex_store_data_o !== '0)
            report_mismatch("wb or store data in reset", ex_wb_value_o | ex_store_data_o, '0);
        if (ex_pc_plus4_o !== '0 || ex_rd_o !== '0)
            report_mismatch("pc_plus4 or rd in reset", ex_pc_plus4_o | 32'(ex_rd_o), '0);
    endtask

    initial
    begin
        seed          = 32'hac98bccd;
        n_checks      = 0;
        n_errors      = 0;
        arst_n_i      = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        instr_valid_i = 1'b0;
        wb_we_i       = 1'b0;
        wb_rd_i       = '0;
        wb_data_i     = '0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        predict(1'b1);  // idle pipe after reset
        repeat (8) @(posedge clk_i);
        #1;
        check_reset_state();
        arst_n_i = 1'b1;
        for (int i = 0; i <= N_INSTR; i++)
        begin
            @(posedge clk_i);
            #1;
            check_outputs();
            flush_next = exp_redir;  // taken redirect squashes the next one
            if (i < N_INSTR)
                drive_random();
            else
                drive_idle();
            predict(flush_next);
            if (wb_we_i && wb_rd_i != '0)
                model_regs[wb_rd_i] = wb_data_i;
        end
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLE)
        begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLE);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
